/* common/trap_pkg.sv */
package trap_pkg;

	// datapath and CSR address widths
	localparam int XLEN       = 32;
	localparam int CSR_ADDR_W = 12;

	// machine CSR addresses
	localparam logic [CSR_ADDR_W-1:0] CSR_MSTATUS = 12'h300;
	localparam logic [CSR_ADDR_W-1:0] CSR_MIE     = 12'h304;
	localparam logic [CSR_ADDR_W-1:0] CSR_MTVEC   = 12'h305;
	localparam logic [CSR_ADDR_W-1:0] CSR_MEPC    = 12'h341;
	localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE  = 12'h342;
	localparam logic [CSR_ADDR_W-1:0] CSR_MIP     = 12'h344;

	// mstatus interrupt enable bits
	localparam int MSTATUS_MIE  = 3;
	localparam int MSTATUS_MPIE = 7;

	// interrupt cause codes, also the bit positions in mie and mip
	localparam int IRQ_TIMER = 7;
	localparam int IRQ_EXT   = 11;

	// exception causes as reported by the stages
	// EXC_MRET is only a marker from ID and never reaches mcause
	typedef enum logic [3:0] {
		EXC_INSTR_MISALIGN = 4'd0,
		EXC_INSTR_FAULT    = 4'd1,
		EXC_ILLEGAL_INSTR  = 4'd2,
		EXC_BREAKPOINT     = 4'd3,
		EXC_LOAD_FAULT     = 4'd5,
		EXC_STORE_FAULT    = 4'd7,
		EXC_ECALL          = 4'd11,
		EXC_MRET           = 4'd15
	} exc_cause_e;

	// one-hot sequencer states
	typedef enum logic [4:0] {
		TRAP_IDLE    = 5'b00001,
		TRAP_MEPC    = 5'b00010,
		TRAP_MCAUSE  = 5'b00100,
		TRAP_MSTATUS = 5'b01000,
		TRAP_MRET    = 5'b10000
	} trap_state_e;

endpackage

/* verilog/irq_pending.sv */
module irq_pending (
	input  logic clk,
	input  logic rst_n,
	input  logic irq_timer_i,
	input  logic irq_ext_i,
	input  logic take_timer_i,
	input  logic take_ext_i,
	output logic pend_timer_o,
	output logic pend_ext_o
);

	logic timer_prev_q;
	logic ext_prev_q;
	logic timer_rise;
	logic ext_rise;
	logic pend_timer_q;
	logic pend_ext_q;

	assign timer_rise = irq_timer_i & ~timer_prev_q;
	assign ext_rise   = irq_ext_i & ~ext_prev_q;

	// previous line levels for edge detect
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			timer_prev_q <= 1'b0;
			ext_prev_q   <= 1'b0;
		end else begin
			timer_prev_q <= irq_timer_i;
			ext_prev_q   <= irq_ext_i;
		end
	end

	// a new edge beats a take in the same cycle
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pend_timer_q <= 1'b0;
			pend_ext_q   <= 1'b0;
		end else begin
			pend_timer_q <= timer_rise | (pend_timer_q & ~take_timer_i);
			pend_ext_q   <= ext_rise | (pend_ext_q & ~take_ext_i);
		end
	end

	assign pend_timer_o = pend_timer_q;
	assign pend_ext_o   = pend_ext_q;

endmodule

/* verilog/csr_file.sv */
module csr_file (
	input  logic                            clk,
	input  logic                            rst_n,
	// software access port
	input  logic [trap_pkg::CSR_ADDR_W-1:0] csr_raddr_i,
	output logic [trap_pkg::XLEN-1:0]       csr_rdata_o,
	input  logic                            csr_we_i,
	input  logic [trap_pkg::CSR_ADDR_W-1:0] csr_waddr_i,
	input  logic [trap_pkg::XLEN-1:0]       csr_wdata_i,
	// trap write port
	input  logic                            tw_en_i,
	input  logic [trap_pkg::CSR_ADDR_W-1:0] tw_addr_i,
	input  logic [trap_pkg::XLEN-1:0]       tw_data_i,
	// pending bits for mip
	input  logic                            pend_timer_i,
	input  logic                            pend_ext_i,
	output logic [trap_pkg::XLEN-1:0]       mtvec_o,
	output logic [trap_pkg::XLEN-1:0]       mepc_o,
	output logic [trap_pkg::XLEN-1:0]       mstatus_o,
	output logic [trap_pkg::XLEN-1:0]       mie_o
);

	import trap_pkg::*;

	logic                  wr_en;
	logic [CSR_ADDR_W-1:0] wr_addr;
	logic [XLEN-1:0]       wr_data;

	// only the implemented bits are stored
	logic [XLEN-1:2]       mtvec_q;
	logic [XLEN-1:2]       mepc_q;
	logic [XLEN-1:0]       mcause_q;
	logic                  mstatus_mie_q;
	logic                  mstatus_mpie_q;
	logic                  mie_timer_q;
	logic                  mie_ext_q;
	logic [XLEN-1:0]       mip;

	// trap port has priority
	assign wr_en   = tw_en_i | csr_we_i;
	assign wr_addr = tw_en_i ? tw_addr_i : csr_waddr_i;
	assign wr_data = tw_en_i ? tw_data_i : csr_wdata_i;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mtvec_q        <= '0;
			mepc_q         <= '0;
			mcause_q       <= '0;
			mstatus_mie_q  <= 1'b0;
			mstatus_mpie_q <= 1'b0;
			mie_timer_q    <= 1'b0;
			mie_ext_q      <= 1'b0;
		end else if (wr_en) begin
			case (wr_addr)
				CSR_MTVEC:  mtvec_q  <= wr_data[XLEN-1:2];
				CSR_MEPC:   mepc_q   <= wr_data[XLEN-1:2];
				CSR_MCAUSE: mcause_q <= wr_data;
				CSR_MSTATUS: begin
					mstatus_mie_q  <= wr_data[MSTATUS_MIE];
					mstatus_mpie_q <= wr_data[MSTATUS_MPIE];
				end
				CSR_MIE: begin
					mie_timer_q <= wr_data[IRQ_TIMER];
					mie_ext_q   <= wr_data[IRQ_EXT];
				end
				// mip and unknown addresses ignore writes
				default: begin
				end
			endcase
		end
	end

	assign mtvec_o = {mtvec_q, 2'b00};
	assign mepc_o  = {mepc_q, 2'b00};

	always_comb begin
		mstatus_o               = '0;
		mstatus_o[MSTATUS_MIE]  = mstatus_mie_q;
		mstatus_o[MSTATUS_MPIE] = mstatus_mpie_q;
	end

	always_comb begin
		mie_o            = '0;
		mie_o[IRQ_TIMER] = mie_timer_q;
		mie_o[IRQ_EXT]   = mie_ext_q;
	end

	// mip mirrors the pending logic
	always_comb begin
		mip            = '0;
		mip[IRQ_TIMER] = pend_timer_i;
		mip[IRQ_EXT]   = pend_ext_i;
	end

	always_comb begin
		case (csr_raddr_i)
			CSR_MSTATUS: csr_rdata_o = mstatus_o;
			CSR_MIE:     csr_rdata_o = mie_o;
			CSR_MTVEC:   csr_rdata_o = mtvec_o;
			CSR_MEPC:    csr_rdata_o = mepc_o;
			CSR_MCAUSE:  csr_rdata_o = mcause_q;
			CSR_MIP:     csr_rdata_o = mip;
			default:     csr_rdata_o = '0;
		endcase
	end

endmodule

/* trap_ctrl/trap_ctrl.sv */
module trap_ctrl (
	input  logic                               clk,
	input  logic                               rst_n,
	// stage reports
	input  logic                               if_exc_valid_i,
	input  trap_pkg::exc_cause_e               if_exc_cause_i,
	input  logic [trap_pkg::XLEN-1:0]          if_exc_pc_i,
	input  logic                               id_exc_valid_i,
	input  trap_pkg::exc_cause_e               id_exc_cause_i,
	input  logic [trap_pkg::XLEN-1:0]          id_exc_pc_i,
	input  logic                               ex_exc_valid_i,
	input  trap_pkg::exc_cause_e               ex_exc_cause_i,
	input  logic [trap_pkg::XLEN-1:0]          ex_exc_pc_i,
	// pending interrupts
	input  logic                               pend_timer_i,
	input  logic                               pend_ext_i,
	// CSR state
	input  logic [trap_pkg::XLEN-1:0]          mtvec_i,
	input  logic [trap_pkg::XLEN-1:0]          mepc_i,
	input  logic [trap_pkg::XLEN-1:0]          mstatus_i,
	input  logic [trap_pkg::XLEN-1:0]          mie_i,
	output logic                               take_timer_o,
	output logic                               take_ext_o,
	// trap write port into the CSR file
	output logic                               tw_en_o,
	output logic [trap_pkg::CSR_ADDR_W-1:0]    tw_addr_o,
	output logic [trap_pkg::XLEN-1:0]          tw_data_o,
	// to the pipeline
	output logic                               busy_o,
	output logic                               redirect_valid_o,
	output logic [trap_pkg::XLEN-1:0]          redirect_pc_o
);

	import trap_pkg::*;

	trap_state_e       state_q;
	trap_state_e       state_d;

	logic              id_sync;
	logic              id_mret;
	logic              ext_en;
	logic              timer_en;

	logic              ev_trap;
	logic              ev_mret;
	logic              ev_irq;
	logic [3:0]        ev_code;
	logic [XLEN-1:0]   ev_pc;

	// latched event, held through the sequence
	logic              irq_q;
	logic [3:0]        code_q;
	logic [XLEN-1:0]   pc_q;
	logic [XLEN-1:0]   target_q;

	assign id_sync  = id_exc_valid_i && (id_exc_cause_i != EXC_MRET);
	assign id_mret  = id_exc_valid_i && (id_exc_cause_i == EXC_MRET);
	assign ext_en   = mstatus_i[MSTATUS_MIE] & mie_i[IRQ_EXT] & pend_ext_i;
	assign timer_en = mstatus_i[MSTATUS_MIE] & mie_i[IRQ_TIMER] & pend_timer_i;

	// event selection, only sampled while idle
	always_comb begin
		ev_trap      = 1'b0;
		ev_mret      = 1'b0;
		ev_irq       = 1'b0;
		ev_code      = '0;
		ev_pc        = id_exc_pc_i;
		take_timer_o = 1'b0;
		take_ext_o   = 1'b0;
		if (state_q == TRAP_IDLE) begin
			// oldest stage first
			if (ex_exc_valid_i) begin
				ev_trap = 1'b1;
				ev_code = ex_exc_cause_i;
				ev_pc   = ex_exc_pc_i;
			end else if (id_sync) begin
				ev_trap = 1'b1;
				ev_code = id_exc_cause_i;
				ev_pc   = id_exc_pc_i;
			end else if (if_exc_valid_i) begin
				ev_trap = 1'b1;
				ev_code = if_exc_cause_i;
				ev_pc   = if_exc_pc_i;
			end else if (id_mret) begin
				ev_mret = 1'b1;
			end else if (ext_en) begin
				ev_trap    = 1'b1;
				ev_irq     = 1'b1;
				ev_code    = 4'(IRQ_EXT);
				take_ext_o = 1'b1;
			end else if (timer_en) begin
				ev_trap      = 1'b1;
				ev_irq       = 1'b1;
				ev_code      = 4'(IRQ_TIMER);
				take_timer_o = 1'b1;
			end
		end
	end

	always_comb begin
		state_d = state_q;
		case (state_q)
			TRAP_IDLE: begin
				if (ev_trap) begin
					state_d = TRAP_MEPC;
				end else if (ev_mret) begin
					state_d = TRAP_MRET;
				end
			end
			TRAP_MEPC:    state_d = TRAP_MCAUSE;
			TRAP_MCAUSE:  state_d = TRAP_MSTATUS;
			TRAP_MSTATUS: state_d = TRAP_IDLE;
			TRAP_MRET:    state_d = TRAP_IDLE;
			default:      state_d = TRAP_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= TRAP_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// target is sampled at the accepting cycle
	always_ff @(posedge clk) begin
		if (ev_trap || ev_mret) begin
			irq_q    <= ev_irq;
			code_q   <= ev_code;
			pc_q     <= ev_pc;
			target_q <= ev_mret ? mepc_i : mtvec_i;
		end
	end

	// one CSR write per busy cycle
	always_comb begin
		tw_en_o   = 1'b0;
		tw_addr_o = '0;
		tw_data_o = '0;
		case (state_q)
			TRAP_MEPC: begin
				tw_en_o   = 1'b1;
				tw_addr_o = CSR_MEPC;
				tw_data_o = pc_q;
			end
			TRAP_MCAUSE: begin
				tw_en_o   = 1'b1;
				tw_addr_o = CSR_MCAUSE;
				tw_data_o = {irq_q, {(XLEN-5){1'b0}}, code_q};
			end
			TRAP_MSTATUS: begin
				tw_en_o                = 1'b1;
				tw_addr_o              = CSR_MSTATUS;
				tw_data_o              = mstatus_i;
				tw_data_o[MSTATUS_MPIE] = mstatus_i[MSTATUS_MIE];
				tw_data_o[MSTATUS_MIE]  = 1'b0;
			end
			TRAP_MRET: begin
				tw_en_o                = 1'b1;
				tw_addr_o              = CSR_MSTATUS;
				tw_data_o              = mstatus_i;
				tw_data_o[MSTATUS_MIE]  = mstatus_i[MSTATUS_MPIE];
				tw_data_o[MSTATUS_MPIE] = 1'b1;
			end
			default: begin
				tw_en_o = 1'b0;
			end
		endcase
	end

	assign busy_o           = (state_q != TRAP_IDLE);
	assign redirect_valid_o = (state_q == TRAP_MSTATUS) || (state_q == TRAP_MRET);
	assign redirect_pc_o    = target_q;

endmodule

/* verilog/trap_unit_top.sv */
module trap_unit_top (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            if_exc_valid_i,
	input  trap_pkg::exc_cause_e            if_exc_cause_i,
	input  logic [trap_pkg::XLEN-1:0]       if_exc_pc_i,
	input  logic                            id_exc_valid_i,
	input  trap_pkg::exc_cause_e            id_exc_cause_i,
	input  logic [trap_pkg::XLEN-1:0]       id_exc_pc_i,
	input  logic                            ex_exc_valid_i,
	input  trap_pkg::exc_cause_e            ex_exc_cause_i,
	input  logic [trap_pkg::XLEN-1:0]       ex_exc_pc_i,
	input  logic                            irq_timer_i,
	input  logic                            irq_ext_i,
	input  logic [trap_pkg::CSR_ADDR_W-1:0] csr_raddr_i,
	output logic [trap_pkg::XLEN-1:0]       csr_rdata_o,
	input  logic                            csr_we_i,
	input  logic [trap_pkg::CSR_ADDR_W-1:0] csr_waddr_i,
	input  logic [trap_pkg::XLEN-1:0]       csr_wdata_i,
	output logic                            busy_o,
	output logic                            redirect_valid_o,
	output logic [trap_pkg::XLEN-1:0]       redirect_pc_o
);

	import trap_pkg::*;

	logic                  pend_timer;
	logic                  pend_ext;
	logic                  take_timer;
	logic                  take_ext;
	logic                  tw_en;
	logic [CSR_ADDR_W-1:0] tw_addr;
	logic [XLEN-1:0]       tw_data;
	logic [XLEN-1:0]       mtvec;
	logic [XLEN-1:0]       mepc;
	logic [XLEN-1:0]       mstatus;
	logic [XLEN-1:0]       mie;

	irq_pending u_irq_pending (
		.clk          (clk),
		.rst_n        (rst_n),
		.irq_timer_i  (irq_timer_i),
		.irq_ext_i    (irq_ext_i),
		.take_timer_i (take_timer),
		.take_ext_i   (take_ext),
		.pend_timer_o (pend_timer),
		.pend_ext_o   (pend_ext)
	);

	trap_ctrl u_trap_ctrl (
		.clk              (clk),
		.rst_n            (rst_n),
		.if_exc_valid_i   (if_exc_valid_i),
		.if_exc_cause_i   (if_exc_cause_i),
		.if_exc_pc_i      (if_exc_pc_i),
		.id_exc_valid_i   (id_exc_valid_i),
		.id_exc_cause_i   (id_exc_cause_i),
		.id_exc_pc_i      (id_exc_pc_i),
		.ex_exc_valid_i   (ex_exc_valid_i),
		.ex_exc_cause_i   (ex_exc_cause_i),
		.ex_exc_pc_i      (ex_exc_pc_i),
		.pend_timer_i     (pend_timer),
		.pend_ext_i       (pend_ext),
		.mtvec_i          (mtvec),
		.mepc_i           (mepc),
		.mstatus_i        (mstatus),
		.mie_i            (mie),
		.take_timer_o     (take_timer),
		.take_ext_o       (take_ext),
		.tw_en_o          (tw_en),
		.tw_addr_o        (tw_addr),
		.tw_data_o        (tw_data),
		.busy_o           (busy_o),
		.redirect_valid_o (redirect_valid_o),
		.redirect_pc_o    (redirect_pc_o)
	);

	csr_file u_csr_file (
		.clk          (clk),
		.rst_n        (rst_n),
		.csr_raddr_i  (csr_raddr_i),
		.csr_rdata_o  (csr_rdata_o),
		.csr_we_i     (csr_we_i),
		.csr_waddr_i  (csr_waddr_i),
		.csr_wdata_i  (csr_wdata_i),
		.tw_en_i      (tw_en),
		.tw_addr_i    (tw_addr),
		.tw_data_i    (tw_data),
		.pend_timer_i (pend_timer),
		.pend_ext_i   (pend_ext),
		.mtvec_o      (mtvec),
		.mepc_o       (mepc),
		.mstatus_o    (mstatus),
		.mie_o        (mie)
	);

endmodule

/* verif/trap_unit_chk.sv */
module trap_unit_chk (
	input  logic                            clk,
	input  logic                            rst_n,
	input  logic                            busy_i,
	input  logic                            redirect_valid_i,
	input  logic                            csr_we_i,
	input  logic                            tw_en_i,
	input  logic [trap_pkg::CSR_ADDR_W-1:0] tw_addr_i,
	input  logic [4:0]                      state_i
);

	timeunit 1ns;
	timeprecision 1ps;

	import trap_pkg::*;

	assert property (@(posedge clk) disable iff (!rst_n) redirect_valid_i |-> busy_i)
		else $error("redirect outside a busy sequence");

	// trap port writes mepc, mcause and mstatus on consecutive cycles
	assert property (@(posedge clk) disable iff (!rst_n)
		tw_en_i && tw_addr_i == CSR_MEPC |=>
			tw_en_i && tw_addr_i == CSR_MCAUSE ##1 tw_en_i && tw_addr_i == CSR_MSTATUS)
		else $error("trap writes out of sequence");

	assert property (@(posedge clk) disable iff (!rst_n) busy_i |-> !csr_we_i)
		else $error("software CSR write while busy");

	assert property (@(posedge clk) disable iff (!rst_n) $onehot(state_i))
		else $error("sequencer state not one-hot");

endmodule

bind trap_unit_top trap_unit_chk u_chk (
	.clk              (clk),
	.rst_n            (rst_n),
	.busy_i           (busy_o),
	.redirect_valid_i (redirect_valid_o),
	.csr_we_i         (csr_we_i),
	.tw_en_i          (tw_en),
	.tw_addr_i        (tw_addr),
	.state_i          (u_trap_ctrl.state_q)
);

/* verif/trap_unit_tb.sv */
module trap_unit_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import trap_pkg::*;

	typedef struct packed {
		logic [XLEN-1:0] mtvec;
		logic [XLEN-1:0] mepc;
		logic [XLEN-1:0] mcause;
		logic [XLEN-1:0] mstatus;
		logic [XLEN-1:0] mie;
	} csr_model_t;

	typedef struct packed {
		logic            v;
		exc_cause_e      cause;
		logic [XLEN-1:0] pc;
	} rep_t;

	typedef struct packed {
		logic            valid;
		logic            is_mret;
		logic            take_ext;
		logic            take_timer;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] mepc;
		logic [XLEN-1:0] mcause;
		logic [XLEN-1:0] mstatus;
	} exp_t;

	logic                  clk;
	logic                  rst_n;
	logic                  if_exc_valid_i;
	exc_cause_e            if_exc_cause_i;
	logic [XLEN-1:0]       if_exc_pc_i;
	logic                  id_exc_valid_i;
	exc_cause_e            id_exc_cause_i;
	logic [XLEN-1:0]       id_exc_pc_i;
	logic                  ex_exc_valid_i;
	exc_cause_e            ex_exc_cause_i;
	logic [XLEN-1:0]       ex_exc_pc_i;
	logic                  irq_timer_i;
	logic                  irq_ext_i;
	logic [CSR_ADDR_W-1:0] csr_raddr_i;
	logic [XLEN-1:0]       csr_rdata_o;
	logic                  csr_we_i;
	logic [CSR_ADDR_W-1:0] csr_waddr_i;
	logic [XLEN-1:0]       csr_wdata_i;
	logic                  busy_o;
	logic                  redirect_valid_o;
	logic [XLEN-1:0]       redirect_pc_o;

	csr_model_t            model;
	logic                  pend_t;
	logic                  pend_e;
	rep_t                  cur_if;
	rep_t                  cur_id;
	rep_t                  cur_ex;
	exp_t                  exp_q[$];
	string                 test_name;
	int                    errors;
	int                    cycles;
	int                    busy_cycles;
	exc_cause_e            sync_causes[7];
	logic [CSR_ADDR_W-1:0] rand_addrs[7];

	trap_unit_top DUT (.*);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// run limit covers the directed part plus 200 random events of up to 12 cycles
	always @(posedge clk) begin
		cycles++;
		if (cycles >= 4000) begin
			$display("run did not finish within %0d cycles", cycles);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	task automatic fail_value(string name, logic [XLEN-1:0] exp, logic [XLEN-1:0] act);
		errors++;
		$display("error %s expected %h actual %h", name, exp, act);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	task automatic fail_note(string what);
		errors++;
		$display("%s in %s", what, test_name);
		$display("SOME TESTS FAILED");
		$fatal(1, "stopping at first error");
	endtask

	// expected outcome of the next accepted event by the priority rules
	function automatic exp_t predict(csr_model_t m, rep_t r_if, rep_t r_id, rep_t r_ex,
			logic pt, logic pe);
		exp_t            e;
		logic            hit;
		logic            irq;
		logic [3:0]      code;
		logic [XLEN-1:0] epc;
		e = '0;
		e.mepc = m.mepc;
		e.mcause = m.mcause;
		e.mstatus = m.mstatus;
		hit = 1'b1;
		irq = 1'b0;
		code = '0;
		epc = r_id.pc;
		if (r_ex.v) begin
			code = r_ex.cause;
			epc = r_ex.pc;
		end else if (r_id.v && r_id.cause != EXC_MRET) begin
			code = r_id.cause;
			epc = r_id.pc;
		end else if (r_if.v) begin
			code = r_if.cause;
			epc = r_if.pc;
		end else if (r_id.v) begin
			hit = 1'b0;
			e.valid = 1'b1;
			e.is_mret = 1'b1;
			e.pc = m.mepc;
			e.mstatus[MSTATUS_MIE] = m.mstatus[MSTATUS_MPIE];
			e.mstatus[MSTATUS_MPIE] = 1'b1;
		end else if (m.mstatus[MSTATUS_MIE] && m.mie[IRQ_EXT] && pe) begin
			irq = 1'b1;
			code = 4'(IRQ_EXT);
			e.take_ext = 1'b1;
		end else if (m.mstatus[MSTATUS_MIE] && m.mie[IRQ_TIMER] && pt) begin
			irq = 1'b1;
			code = 4'(IRQ_TIMER);
			e.take_timer = 1'b1;
		end else begin
			hit = 1'b0;
		end
		if (hit) begin
			e.valid = 1'b1;
			e.pc = m.mtvec;
			e.mepc = epc & ~32'h3;
			e.mcause = {irq, {(XLEN-5){1'b0}}, code};
			e.mstatus[MSTATUS_MPIE] = m.mstatus[MSTATUS_MIE];
			e.mstatus[MSTATUS_MIE] = 1'b0;
		end
		return e;
	endfunction

	task automatic drive_reports(rep_t r_if, rep_t r_id, rep_t r_ex);
		cur_if = r_if;
		cur_id = r_id;
		cur_ex = r_ex;
		if_exc_valid_i = r_if.v;
		if_exc_cause_i = r_if.cause;
		if_exc_pc_i = r_if.pc;
		id_exc_valid_i = r_id.v;
		id_exc_cause_i = r_id.cause;
		id_exc_pc_i = r_id.pc;
		ex_exc_valid_i = r_ex.v;
		ex_exc_cause_i = r_ex.cause;
		ex_exc_pc_i = r_ex.pc;
	endtask

	task automatic read_check(string name, logic [CSR_ADDR_W-1:0] addr, logic [XLEN-1:0] exp);
		@(posedge clk);
		#10;
		csr_raddr_i = addr;
		@(negedge clk);
		assert (csr_rdata_o === exp) else fail_value(name, exp, csr_rdata_o);
	endtask

	task automatic sw_write(logic [CSR_ADDR_W-1:0] addr, logic [XLEN-1:0] data);
		@(posedge clk);
		#10;
		csr_we_i = 1'b1;
		csr_waddr_i = addr;
		csr_wdata_i = data;
		@(posedge clk);
		#10;
		csr_we_i = 1'b0;
		case (addr)
			CSR_MTVEC:   model.mtvec = data & ~32'h3;
			CSR_MEPC:    model.mepc = data & ~32'h3;
			CSR_MCAUSE:  model.mcause = data;
			CSR_MSTATUS: model.mstatus = data & ((32'h1 << MSTATUS_MIE) | (32'h1 << MSTATUS_MPIE));
			CSR_MIE:     model.mie = data & ((32'h1 << IRQ_TIMER) | (32'h1 << IRQ_EXT));
			default: begin
			end
		endcase
	endtask

	task automatic wait_redirect();
		while (!redirect_valid_o) begin
			@(posedge clk);
			#10;
		end
	endtask

	// queue the expectation, wait for the sequence, then read back the CSRs
	task automatic run_expect(exp_t e);
		rep_t idle_if;
		rep_t idle_id;
		rep_t idle_ex;
		exp_q.push_back(e);
		wait_redirect();
		idle_if = cur_if;
		idle_id = cur_id;
		idle_ex = cur_ex;
		idle_if.v = 1'b0;
		idle_id.v = 1'b0;
		idle_ex.v = 1'b0;
		drive_reports(idle_if, idle_id, idle_ex);
		model.mepc = e.mepc;
		model.mcause = e.mcause;
		model.mstatus = e.mstatus;
		if (e.take_ext)
			pend_e = 1'b0;
		if (e.take_timer)
			pend_t = 1'b0;
		if (e.is_mret) begin
			read_check({test_name, " mstatus"}, CSR_MSTATUS, e.mstatus);
		end else begin
			read_check({test_name, " mepc"}, CSR_MEPC, e.mepc);
			read_check({test_name, " mcause"}, CSR_MCAUSE, e.mcause);
			read_check({test_name, " mstatus"}, CSR_MSTATUS, e.mstatus);
		end
	endtask

	// take every interrupt that the model says is now enabled
	task automatic settle();
		exp_t e;
		e = predict(model, cur_if, cur_id, cur_ex, pend_t, pend_e);
		while (e.valid) begin
			run_expect(e);
			e = predict(model, cur_if, cur_id, cur_ex, pend_t, pend_e);
		end
	endtask

	task automatic run_event(rep_t r_if, rep_t r_id, rep_t r_ex);
		exp_t e;
		@(posedge clk);
		#10;
		drive_reports(r_if, r_id, r_ex);
		e = predict(model, r_if, r_id, r_ex, pend_t, pend_e);
		if (e.valid) begin
			run_expect(e);
		end else begin
			r_if.v = 1'b0;
			r_id.v = 1'b0;
			r_ex.v = 1'b0;
			@(posedge clk);
			#10;
			drive_reports(r_if, r_id, r_ex);
		end
		settle();
	endtask

	task automatic irq_pulse(logic timer, logic ext);
		@(posedge clk);
		#10;
		irq_timer_i = timer;
		irq_ext_i = ext;
		@(posedge clk);
		#10;
		irq_timer_i = 1'b0;
		irq_ext_i = 1'b0;
		pend_t = pend_t | timer;
		pend_e = pend_e | ext;
		settle();
	endtask

	// each redirect pulse is matched against the oldest expectation
	always @(negedge clk) begin : compare_redirect
		exp_t e;
		int   exp_busy;
		if (!rst_n || !busy_o) begin
			busy_cycles = 0;
		end else begin
			busy_cycles++;
		end
		if (rst_n && redirect_valid_o) begin
			assert (exp_q.size() > 0) else fail_note("redirect with no expected event");
			e = exp_q.pop_front();
			assert (redirect_pc_o === e.pc)
				else fail_value({test_name, " redirect"}, e.pc, redirect_pc_o);
			// a trap holds the pipeline for three cycles, an mret for one
			exp_busy = e.is_mret ? 1 : 3;
			assert (busy_cycles == exp_busy)
				else fail_value({test_name, " busy cycles"}, exp_busy, busy_cycles);
		end
	end

	initial begin
		rep_t          a;
		rep_t          b;
		rep_t          c;
		int            op;
		logic [2:0]    sel;
		void'($urandom(32'h748e_03ae));
		sync_causes = '{EXC_INSTR_MISALIGN, EXC_INSTR_FAULT, EXC_ILLEGAL_INSTR,
			EXC_BREAKPOINT, EXC_LOAD_FAULT, EXC_STORE_FAULT, EXC_ECALL};
		rand_addrs = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MIP, 12'h7c0};
		errors = 0;
		cycles = 0;
		model = '0;
		pend_t = 1'b0;
		pend_e = 1'b0;
		rst_n = 1'b0;
		irq_timer_i = 1'b0;
		irq_ext_i = 1'b0;
		csr_raddr_i = '0;
		csr_we_i = 1'b0;
		csr_waddr_i = '0;
		csr_wdata_i = '0;
		drive_reports('{1'b0, EXC_ECALL, 32'h0}, '{1'b0, EXC_ECALL, 32'h0},
			'{1'b0, EXC_ECALL, 32'h0});
		repeat (8) @(posedge clk);
		#10;
		rst_n = 1'b1;

		test_name = "reset";
		assert (!busy_o && !redirect_valid_o) else fail_note("busy or redirect high after reset");
		foreach (rand_addrs[i])
			read_check(test_name, rand_addrs[i], '0);

		test_name = "masking";
		sw_write(CSR_MTVEC, 32'hffff_ffff);
		read_check(test_name, CSR_MTVEC, 32'hffff_fffc);
		sw_write(CSR_MIE, 32'hffff_ffff);
		read_check(test_name, CSR_MIE, 32'h0000_0880);
		sw_write(CSR_MSTATUS, 32'hffff_ffff);
		read_check(test_name, CSR_MSTATUS, 32'h0000_0088);
		sw_write(CSR_MIP, 32'hffff_ffff);
		read_check(test_name, CSR_MIP, 32'h0);
		sw_write(CSR_MIE, 32'h0);
		sw_write(CSR_MSTATUS, 32'h8);
		sw_write(CSR_MTVEC, 32'h0000_0100);

		test_name = "single stage";
		run_event('{1'b1, EXC_INSTR_FAULT, 32'h1000}, '{1'b0, EXC_ECALL, 32'h2000},
			'{1'b0, EXC_ECALL, 32'h3000});
		run_event('{1'b0, EXC_ECALL, 32'h1000}, '{1'b1, EXC_ILLEGAL_INSTR, 32'h2004},
			'{1'b0, EXC_ECALL, 32'h3000});
		run_event('{1'b0, EXC_ECALL, 32'h1000}, '{1'b0, EXC_ECALL, 32'h2000},
			'{1'b1, EXC_LOAD_FAULT, 32'h3008});
		test_name = "several stages";
		run_event('{1'b1, EXC_INSTR_MISALIGN, 32'h1002}, '{1'b1, EXC_ECALL, 32'h2010},
			'{1'b1, EXC_STORE_FAULT, 32'h3010});
		run_event('{1'b1, EXC_INSTR_MISALIGN, 32'h1002}, '{1'b1, EXC_BREAKPOINT, 32'h2014},
			'{1'b0, EXC_ECALL, 32'h3010});

		test_name = "mret";
		run_event('{1'b0, EXC_ECALL, 32'h0}, '{1'b1, EXC_MRET, 32'h2020},
			'{1'b0, EXC_ECALL, 32'h0});

		test_name = "interrupts";
		sw_write(CSR_MSTATUS, 32'h0);
		irq_pulse(1'b0, 1'b1);
		read_check(test_name, CSR_MIP, 32'h0000_0800);
		sw_write(CSR_MIE, 32'h0000_0880);
		settle();
		sw_write(CSR_MSTATUS, 32'h8);
		settle();
		irq_pulse(1'b1, 1'b1);
		run_event('{1'b0, EXC_ECALL, 32'h0}, '{1'b1, EXC_MRET, 32'h2040},
			'{1'b0, EXC_ECALL, 32'h0});
		run_event('{1'b0, EXC_ECALL, 32'h0}, '{1'b1, EXC_MRET, 32'h2044},
			'{1'b0, EXC_ECALL, 32'h0});

		test_name = "random";
		for (int n = 0; n < 200; n++) begin
			op = $urandom % 4;
			a = '{1'b0, sync_causes[$urandom % 7], $urandom};
			b = '{1'b0, sync_causes[$urandom % 7], $urandom};
			c = '{1'b0, sync_causes[$urandom % 7], $urandom};
			case (op)
				0: begin
					sw_write(rand_addrs[$urandom % 7], $urandom);
					settle();
				end
				1: begin
					sel = 3'($urandom % 7 + 1);
					a.v = sel[0];
					b.v = sel[1];
					c.v = sel[2];
					run_event(a, b, c);
				end
				2: begin
					b.v = 1'b1;
					b.cause = EXC_MRET;
					run_event(a, b, c);
				end
				default: irq_pulse(1'($urandom), 1'($urandom));
			endcase
		end

		repeat (4) @(posedge clk);
		if (errors == 0 && exp_q.size() == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

/* vlog.f */
common/trap_pkg.sv
verilog/irq_pending.sv
verilog/csr_file.sv
trap_ctrl/trap_ctrl.sv
verilog/trap_unit_top.sv
verif/trap_unit_chk.sv
verif/trap_unit_tb.sv

/* Bender.yml */
package:
  name: trap_unit

sources:
  - common/trap_pkg.sv
  - verilog/irq_pending.sv
  - verilog/csr_file.sv
  - trap_ctrl/trap_ctrl.sv
  - verilog/trap_unit_top.sv
  - target: test
    files:
      - verif/trap_unit_chk.sv
      - verif/trap_unit_tb.sv
